// File: mini_backend.f
+incdir+.
mini_backend_isa_pkg.sv
mini_backend_pipe_pkg.sv
mini_backend_if.sv
mini_decode.sv
mini_execute.sv
mini_result.sv
mini_backend.sv
tb_mini_backend.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mini_backend -f mini_backend.f

out=$(./obj_dir/Vtb_mini_backend 2>&1) || true
echo "$out"

echo "$out" | grep -q "Simulation completed successfully"

// File: tb_mini_backend.sv
`timescale 1ns/1ps
`include "mini_backend_defs.svh"

module tb_mini_backend;
  import mini_backend_isa_pkg::*;

  localparam int NUM_BEATS = 2000;
  localparam int RESET_CYC = 10;
  localparam int WATCH_CYC = NUM_BEATS * 10;

  typedef struct packed {
    logic [`MB_XLEN-1:0] word;
    logic [`MB_XLEN-1:0] pc;
    logic                epoch;
  } beat_t;

  logic                clk;
  logic                rst_n;
  logic                inst_valid_i;
  logic                inst_ready_o;
  logic [`MB_XLEN-1:0] inst_word_i;
  logic [`MB_XLEN-1:0] inst_pc_i;
  logic                inst_epoch_i;
  logic                retire_valid_o;
  logic                retire_ready_i;
  logic [`MB_XLEN-1:0] retire_pc_o;
  reg_idx_t            retire_rd_o;
  logic                retire_we_o;
  logic [`MB_XLEN-1:0] retire_data_o;
  logic                retire_illegal_o;
  logic                redirect_valid_o;
  logic [`MB_XLEN-1:0] redirect_pc_o;

  integer              seed;
  logic [`MB_XLEN-1:0] model_regs [`MB_NREGS];
  logic                model_epoch;
  beat_t               sent_q [$];
  logic [`MB_XLEN-1:0] fe_pc;
  logic                fe_epoch;
  logic                hold_beat;
  logic                switch_pending;
  logic [`MB_XLEN-1:0] new_pc;
  int                  stale_left;
  int                  beats_sent;
  int                  retired;
  int                  redirects;
  int                  illegals;

  mini_backend i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .inst_valid_i     (inst_valid_i),
    .inst_ready_o     (inst_ready_o),
    .inst_word_i      (inst_word_i),
    .inst_pc_i        (inst_pc_i),
    .inst_epoch_i     (inst_epoch_i),
    .retire_valid_o   (retire_valid_o),
    .retire_ready_i   (retire_ready_i),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_we_o      (retire_we_o),
    .retire_data_o    (retire_data_o),
    .retire_illegal_o (retire_illegal_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  // mostly r0 to r3 so hazards are frequent
  function automatic reg_idx_t pick_reg();
    reg_idx_t idx;
    if (rand_below(4) != 0) begin
      idx = reg_idx_t'(rand_below(4));
    end else begin
      idx = reg_idx_t'(rand_below(`MB_NREGS));
    end
    return idx;
  endfunction

  function automatic logic [`MB_XLEN-1:0] make_word(input int idx);
    logic [31:0]         r;
    logic [3:0]          op;
    int unsigned         pick;
    logic [`MB_XLEN-1:0] word;
    r = $random(seed);
    if (idx < `MB_NREGS - 1) begin
      // first give every register a known value
      word = {OP_ADDI, reg_idx_t'(idx + 1), 4'd0, 4'd0, r[15:0]};
    end else begin
      pick = rand_below(100);
      if (pick < 10) begin
        op = 4'(13 + pick % 3);
      end else begin
        op = 4'(rand_below(13));
      end
      word = {op, pick_reg(), pick_reg(), pick_reg(), r[15:0]};
    end
    return word;
  endfunction

  // reference model of one instruction
  task automatic predict_result(
    input  beat_t               b,
    output logic                we,
    output logic [`MB_XLEN-1:0] data,
    output logic                ill,
    output logic                taken,
    output logic [`MB_XLEN-1:0] target
  );
    instr_u              w;
    logic [`MB_XLEN-1:0] v1;
    logic [`MB_XLEN-1:0] v2;
    logic [`MB_XLEN-1:0] vd;
    logic [`MB_XLEN-1:0] simm;
    w      = b.word;
    v1     = model_regs[w.r.rs1];
    v2     = model_regs[w.r.rs2];
    vd     = model_regs[w.i.rd];
    simm   = {{(`MB_XLEN-`MB_IMM_W){w.i.imm[`MB_IMM_W-1]}}, w.i.imm};
    we     = 1'b1;
    ill    = 1'b0;
    taken  = 1'b0;
    data   = '0;
    target = b.pc + (simm << 2);
    case (w.r.opcode)
      OP_ADD:  data = v1 + v2;
      OP_SUB:  data = v1 - v2;
      OP_AND:  data = v1 & v2;
      OP_OR:   data = v1 | v2;
      OP_XOR:  data = v1 ^ v2;
      OP_SLL:  data = v1 << v2[4:0];
      OP_SRL:  data = v1 >> v2[4:0];
      OP_SLT:  data = ($signed(v1) < $signed(v2)) ? 32'd1 : 32'd0;
      OP_ADDI: data = v1 + simm;
      OP_ORI:  data = v1 | {16'h0, w.i.imm};
      OP_LUI:  data = {w.i.imm, 16'h0};
      OP_BEQ: begin
        we    = 1'b0;
        taken = (v1 == vd);
      end
      OP_BNE: begin
        we    = 1'b0;
        taken = (v1 != vd);
      end
      default: begin
        we  = 1'b0;
        ill = 1'b1;
      end
    endcase
  endtask

  task automatic check_quiet(input string name, input logic act);
    if (act !== 1'b0) begin
      fail_run($sformatf("Error at %0t ns: %s expected 0, got %b", $time, name, act));
    end
  endtask

  task automatic check_retire(
    input logic [`MB_XLEN-1:0] exp_pc,
    input reg_idx_t            exp_rd,
    input logic                exp_we,
    input logic [`MB_XLEN-1:0] exp_data,
    input logic                exp_ill
  );
    if (retire_pc_o !== exp_pc) begin
      fail_run($sformatf("Error at %0t ns: retire_pc_o expected %h, got %h",
                         $time, exp_pc, retire_pc_o));
    end else if (retire_rd_o !== exp_rd) begin
      fail_run($sformatf("Error at %0t ns: retire_rd_o expected %0d, got %0d",
                         $time, exp_rd, retire_rd_o));
    end else if (retire_we_o !== exp_we) begin
      fail_run($sformatf("Error at %0t ns: retire_we_o expected %b, got %b",
                         $time, exp_we, retire_we_o));
    end else if (retire_data_o !== exp_data) begin
      fail_run($sformatf("Error at %0t ns: retire_data_o expected %h, got %h",
                         $time, exp_data, retire_data_o));
    end else if (retire_illegal_o !== exp_ill) begin
      fail_run($sformatf("Error at %0t ns: retire_illegal_o expected %b, got %b",
                         $time, exp_ill, retire_illegal_o));
    end
  endtask

  task automatic check_redirect(input logic exp_valid, input logic [`MB_XLEN-1:0] exp_pc);
    if (redirect_valid_o !== exp_valid) begin
      fail_run($sformatf("Error at %0t ns: redirect_valid_o expected %b, got %b",
                         $time, exp_valid, redirect_valid_o));
    end else if (exp_valid && redirect_pc_o !== exp_pc) begin
      fail_run($sformatf("Error at %0t ns: redirect_pc_o expected %h, got %h",
                         $time, exp_pc, redirect_pc_o));
    end
  endtask

  function automatic int live_count();
    int n;
    n = 0;
    foreach (sent_q[k]) begin
      if (sent_q[k].epoch == model_epoch) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic handle_retire();
    beat_t               head;
    instr_u              w;
    logic                exp_we;
    logic [`MB_XLEN-1:0] exp_data;
    logic                exp_ill;
    logic                exp_taken;
    logic [`MB_XLEN-1:0] exp_target;
    // beats fetched behind a taken branch never retire
    while (sent_q.size() > 0 && sent_q[0].epoch != model_epoch) begin
      sent_q.delete(0);
    end
    if (sent_q.size() == 0) begin
      fail_run($sformatf("Error at %0t ns: an instruction retired that was never sent", $time));
    end else begin
      head = sent_q.pop_front();
      w    = head.word;
      predict_result(head, exp_we, exp_data, exp_ill, exp_taken, exp_target);
      check_retire(head.pc, w.r.rd, exp_we, exp_data, exp_ill);
      check_redirect(exp_taken, exp_target);
      if (exp_we && w.r.rd != '0) begin
        model_regs[w.r.rd] = exp_data;
      end
      if (exp_taken) begin
        model_epoch = !model_epoch;
        redirects++;
      end
      if (exp_ill) begin
        illegals++;
      end
      retired++;
    end
  endtask

  task automatic drive_inputs();
    retire_ready_i = rand_below(10) >= 3;
    if (!hold_beat) begin
      // wrong-path beats go out first, then the frontend follows the redirect
      if (switch_pending && stale_left == 0) begin
        fe_pc          = new_pc;
        fe_epoch       = !fe_epoch;
        switch_pending = 1'b0;
      end
      if (beats_sent < NUM_BEATS && rand_below(10) >= 2) begin
        inst_valid_i = 1'b1;
        inst_word_i  = make_word(beats_sent);
        inst_pc_i    = fe_pc;
        inst_epoch_i = fe_epoch;
      end else begin
        inst_valid_i = 1'b0;
      end
    end
  endtask

  task automatic run_cycle();
    logic                inst_fire;
    logic                redir;
    logic [`MB_XLEN-1:0] redir_pc;
    beat_t               b;
    @(negedge clk);
    inst_fire = inst_valid_i && inst_ready_o;
    redir     = redirect_valid_o;
    redir_pc  = redirect_pc_o;
    if (retire_valid_o && retire_ready_i) begin
      handle_retire();
    end else begin
      check_redirect(1'b0, '0);
    end
    if (inst_fire) begin
      b.word  = inst_word_i;
      b.pc    = inst_pc_i;
      b.epoch = inst_epoch_i;
      sent_q.push_back(b);
      beats_sent++;
      fe_pc = inst_pc_i + 32'd4;
      if (stale_left > 0) begin
        stale_left--;
      end
    end
    if (redir) begin
      new_pc         = redir_pc;
      stale_left     = rand_below(3);
      switch_pending = 1'b1;
    end
    hold_beat = inst_valid_i && !inst_fire && !redir;
    @(posedge clk);
    #1;
    drive_inputs();
  endtask

  initial begin
    seed           = 32'h6bee_976b;
    rst_n          = 1'b0;
    inst_valid_i   = 1'b0;
    inst_word_i    = '0;
    inst_pc_i      = '0;
    inst_epoch_i   = 1'b0;
    retire_ready_i = 1'b0;
    model_epoch    = 1'b0;
    fe_pc          = '0;
    fe_epoch       = 1'b0;
    hold_beat      = 1'b0;
    switch_pending = 1'b0;
    new_pc         = '0;
    stale_left     = 0;
    beats_sent     = 0;
    retired        = 0;
    redirects      = 0;
    illegals       = 0;
    foreach (model_regs[k]) begin
      model_regs[k] = '0;
    end
    repeat (RESET_CYC) begin
      @(posedge clk);
      #1;
      check_quiet("inst_ready_o", inst_ready_o);
      check_quiet("retire_valid_o", retire_valid_o);
      check_quiet("redirect_valid_o", redirect_valid_o);
    end
    rst_n = 1'b1;
    while (beats_sent < NUM_BEATS || live_count() != 0) begin
      run_cycle();
    end
    // idle tail where any late retire is caught as unexpected
    repeat (20) begin
      run_cycle();
    end
    $display("retired %0d, redirects %0d, illegal %0d", retired, redirects, illegals);
    if (redirects == 0 || illegals == 0) begin
      fail_run("Error: run ended without a taken branch or without an illegal opcode");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

  initial begin
    repeat (RESET_CYC + WATCH_CYC) @(posedge clk);
    fail_run("Error: watchdog expired before all instructions retired");
  end

endmodule

// File: mini_backend.sv
`timescale 1ns/1ps
`include "mini_backend_defs.svh"

module mini_backend (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            inst_valid_i,
  output logic                            inst_ready_o,
  input  logic [`MB_XLEN-1:0]             inst_word_i,
  input  logic [`MB_XLEN-1:0]             inst_pc_i,
  input  logic                            inst_epoch_i,
  output logic                            retire_valid_o,
  input  logic                            retire_ready_i,
  output logic [`MB_XLEN-1:0]             retire_pc_o,
  output mini_backend_isa_pkg::reg_idx_t  retire_rd_o,
  output logic                            retire_we_o,
  output logic [`MB_XLEN-1:0]             retire_data_o,
  output logic                            retire_illegal_o,
  output logic                            redirect_valid_o,
  output logic [`MB_XLEN-1:0]             redirect_pc_o
);

  issue_if  issue ();
  exec_if   exec ();
  commit_if commit ();

  mini_decode i_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid_i (inst_valid_i),
    .inst_ready_o (inst_ready_o),
    .inst_word_i  (inst_word_i),
    .inst_pc_i    (inst_pc_i),
    .inst_epoch_i (inst_epoch_i),
    .issue        (issue.decode),
    .commit       (commit.decode)
  );

  mini_execute i_execute (
    .clk    (clk),
    .rst_n  (rst_n),
    .issue  (issue.execute),
    .exec   (exec.execute),
    .commit (commit.execute)
  );

  mini_result i_result (
    .clk              (clk),
    .rst_n            (rst_n),
    .exec             (exec.result),
    .commit           (commit.result),
    .retire_valid_o   (retire_valid_o),
    .retire_ready_i   (retire_ready_i),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_we_o      (retire_we_o),
    .retire_data_o    (retire_data_o),
    .retire_illegal_o (retire_illegal_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

endmodule

// File: mini_result.sv
`timescale 1ns/1ps
`include "mini_backend_defs.svh"

module mini_result (
  input  logic                            clk,
  input  logic                            rst_n,
  exec_if.result                          exec,
  commit_if.result                        commit,
  output logic                            retire_valid_o,
  input  logic                            retire_ready_i,
  output logic [`MB_XLEN-1:0]             retire_pc_o,
  output mini_backend_isa_pkg::reg_idx_t  retire_rd_o,
  output logic                            retire_we_o,
  output logic [`MB_XLEN-1:0]             retire_data_o,
  output logic                            retire_illegal_o,
  output logic                            redirect_valid_o,
  output logic [`MB_XLEN-1:0]             redirect_pc_o
);
  import mini_backend_pipe_pkg::*;

  logic    r_valid_q;
  result_t r_q;
  logic    epoch_q;
  logic    retire_fire;

  assign exec.ready  = !r_valid_q || retire_ready_i;
  assign retire_fire = r_valid_q && retire_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_valid_q <= 1'b0;
      epoch_q   <= 1'b0;
    end else if (redirect_valid_o) begin
      // anything behind a taken branch is wrong path
      r_valid_q <= 1'b0;
      epoch_q   <= !epoch_q;
    end else if (exec.ready) begin
      r_valid_q <= exec.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (exec.valid && exec.ready) begin
      r_q <= exec.payload;
    end
  end

  assign retire_valid_o   = r_valid_q;
  assign retire_pc_o      = r_q.pc;
  assign retire_rd_o      = r_q.rd;
  assign retire_we_o      = r_q.we;
  assign retire_data_o    = r_q.data;
  assign retire_illegal_o = r_q.illegal;
  assign redirect_valid_o = retire_fire && r_q.br_taken;
  assign redirect_pc_o    = r_q.br_target;

  assign commit.wb_valid = retire_fire && r_q.we;
  assign commit.wb_rd    = r_q.rd;
  assign commit.wb_data  = r_q.data;
  assign commit.flush    = redirect_valid_o;
  assign commit.epoch    = epoch_q;

  // the flush empties execute too so two idle retire cycles follow a redirect
  a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_valid_o |=> !retire_valid_o ##1 !retire_valid_o);

endmodule

// File: mini_execute.sv
`timescale 1ns/1ps
`include "mini_backend_defs.svh"

module mini_execute (
  input  logic       clk,
  input  logic       rst_n,
  issue_if.execute   issue,
  exec_if.execute    exec,
  commit_if.execute  commit
);
  import mini_backend_isa_pkg::*;
  import mini_backend_pipe_pkg::*;

  logic                x_valid_q;
  issue_t              x_q;
  logic [`MB_XLEN-1:0] alu_data;
  logic                taken;

  assign issue.ready = !x_valid_q || exec.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x_valid_q <= 1'b0;
    end else if (commit.flush) begin
      x_valid_q <= 1'b0;
    end else if (issue.ready) begin
      x_valid_q <= issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue.valid && issue.ready) begin
      x_q <= issue.payload;
    end
  end

  always_comb begin
    alu_data = '0;
    taken    = 1'b0;
    case (x_q.opcode)
      OP_ADD:  alu_data = x_q.op_a + x_q.op_b;
      OP_SUB:  alu_data = x_q.op_a - x_q.op_b;
      OP_AND:  alu_data = x_q.op_a & x_q.op_b;
      OP_OR:   alu_data = x_q.op_a | x_q.op_b;
      OP_XOR:  alu_data = x_q.op_a ^ x_q.op_b;
      // shift amount from the low five bits
      OP_SLL:  alu_data = x_q.op_a << x_q.op_b[4:0];
      OP_SRL:  alu_data = x_q.op_a >> x_q.op_b[4:0];
      OP_SLT:  alu_data = {{(`MB_XLEN-1){1'b0}}, $signed(x_q.op_a) < $signed(x_q.op_b)};
      OP_ADDI: alu_data = x_q.op_a + x_q.imm;
      OP_ORI:  alu_data = x_q.op_a | x_q.imm;
      OP_LUI:  alu_data = x_q.imm;
      OP_BEQ:  taken = x_q.op_a == x_q.op_b;
      OP_BNE:  taken = x_q.op_a != x_q.op_b;
      default: alu_data = '0;
    endcase
  end

  assign exec.valid = x_valid_q;

  always_comb begin
    exec.payload.pc        = x_q.pc;
    exec.payload.rd        = x_q.rd;
    exec.payload.we        = x_q.we && !x_q.illegal;
    exec.payload.illegal   = x_q.illegal;
    exec.payload.data      = alu_data;
    exec.payload.br_taken  = taken;
    // word offset from the branch pc
    exec.payload.br_target = x_q.pc + {x_q.imm[`MB_XLEN-3:0], 2'b00};
  end

  // held result must not move while the retire stage stalls
  a_exec_stable: assert property (@(posedge clk) disable iff (!rst_n || commit.flush)
    exec.valid && !exec.ready |=> exec.valid && $stable(exec.payload));

endmodule

// File: mini_decode.sv
`timescale 1ns/1ps
`include "mini_backend_defs.svh"

module mini_decode (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          inst_valid_i,
  output logic                          inst_ready_o,
  input  mini_backend_isa_pkg::instr_u  inst_word_i,
  input  logic [`MB_XLEN-1:0]           inst_pc_i,
  input  logic                          inst_epoch_i,
  issue_if.decode                       issue,
  commit_if.decode                      commit
);
  import mini_backend_isa_pkg::*;

  logic                 in_ready_q;
  logic                 skid_busy_q;
  instr_u               skid_word_q;
  logic [`MB_XLEN-1:0]  skid_pc_q;
  logic                 skid_epoch_q;
  logic                 cand_valid;
  logic                 cand_live;
  instr_u               cand_word;
  logic [`MB_XLEN-1:0]  cand_pc;
  logic                 cand_epoch;
  logic                 d_valid_q;
  instr_u               d_word_q;
  logic [`MB_XLEN-1:0]  d_pc_q;
  logic                 d_ready;
  logic                 issue_fire;
  logic [`MB_XLEN-1:0]  regs [`MB_NREGS];
  logic [`MB_NREGS-1:0] pend_q;
  logic [`MB_NREGS-1:0] wb_clr;
  logic [`MB_NREGS-1:0] pend_eff;
  opcode_t              op;
  reg_idx_t             rd;
  reg_idx_t             src_idx [2];
  logic [`MB_XLEN-1:0]  src_data [2];
  logic [1:0]           use_src;
  logic                 illegal;
  logic                 branch;
  logic                 writes;
  logic                 hazard;
  logic [`MB_XLEN-1:0]  imm_ext;

  // skid register in front of the decode register
  assign inst_ready_o = in_ready_q;
  assign cand_valid   = skid_busy_q || (inst_valid_i && in_ready_q);
  assign cand_word    = skid_busy_q ? skid_word_q : inst_word_i;
  assign cand_pc      = skid_busy_q ? skid_pc_q : inst_pc_i;
  assign cand_epoch   = skid_busy_q ? skid_epoch_q : inst_epoch_i;
  // stale epoch beats are simply dropped here
  assign cand_live    = cand_valid && (cand_epoch == commit.epoch);
  assign issue_fire   = issue.valid && issue.ready;
  assign d_ready      = !d_valid_q || issue_fire;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_ready_q  <= 1'b0;
      skid_busy_q <= 1'b0;
      d_valid_q   <= 1'b0;
    end else if (commit.flush) begin
      in_ready_q  <= 1'b1;
      skid_busy_q <= 1'b0;
      // a beat already on the new epoch survives
      d_valid_q   <= cand_valid && (cand_epoch != commit.epoch);
    end else begin
      in_ready_q  <= !(cand_live && !d_ready);
      skid_busy_q <= cand_live && !d_ready;
      if (d_ready) begin
        d_valid_q <= cand_live;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!skid_busy_q) begin
      skid_word_q  <= inst_word_i;
      skid_pc_q    <= inst_pc_i;
      skid_epoch_q <= inst_epoch_i;
    end
    if (d_ready || commit.flush) begin
      d_word_q <= cand_word;
      d_pc_q   <= cand_pc;
    end
  end

  assign op         = d_word_q.r.opcode;
  assign rd         = d_word_q.r.rd;
  assign illegal    = op > OP_BNE;
  assign branch     = (op == OP_BEQ) || (op == OP_BNE);
  assign writes     = !illegal && !branch;
  assign src_idx[0] = d_word_q.r.rs1;
  assign src_idx[1] = branch ? rd : d_word_q.r.rs2;
  assign use_src[0] = !illegal && (op != OP_LUI);
  assign use_src[1] = branch || (op <= OP_SLT);

  // write-through register file with r0 tied low
  always_ff @(posedge clk) begin
    if (commit.wb_valid && commit.wb_rd != '0) begin
      regs[commit.wb_rd] <= commit.wb_data;
    end
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      if (src_idx[p] == '0) begin
        src_data[p] = '0;
      end else if (commit.wb_valid && commit.wb_rd == src_idx[p]) begin
        src_data[p] = commit.wb_data;
      end else begin
        src_data[p] = regs[src_idx[p]];
      end
    end
  end

  // same-cycle writeback already counts as done on the scoreboard
  always_comb begin
    wb_clr = '0;
    if (commit.wb_valid) begin
      wb_clr[commit.wb_rd] = 1'b1;
    end
  end

  assign pend_eff = pend_q & ~wb_clr;
  // waw also blocks so an older writeback cannot clear a newer pending bit
  assign hazard   = (use_src[0] && pend_eff[src_idx[0]]) ||
                    (use_src[1] && pend_eff[src_idx[1]]) ||
                    (writes && pend_eff[rd]);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q <= '0;
    end else if (commit.flush) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_eff;
      if (issue_fire && writes && rd != '0) begin
        pend_q[rd] <= 1'b1;
      end
    end
  end

  always_comb begin
    case (op)
      OP_ORI:  imm_ext = {{(`MB_XLEN-`MB_IMM_W){1'b0}}, d_word_q.i.imm};
      OP_LUI:  imm_ext = {d_word_q.i.imm, {(`MB_XLEN-`MB_IMM_W){1'b0}}};
      default: imm_ext = {{(`MB_XLEN-`MB_IMM_W){d_word_q.i.imm[`MB_IMM_W-1]}}, d_word_q.i.imm};
    endcase
  end

  assign issue.valid = d_valid_q && !hazard;

  always_comb begin
    issue.payload.pc      = d_pc_q;
    issue.payload.opcode  = op;
    issue.payload.rd      = rd;
    issue.payload.we      = writes;
    issue.payload.illegal = illegal;
    issue.payload.op_a    = src_data[0];
    issue.payload.op_b    = src_data[1];
    issue.payload.imm     = imm_ext;
  end

  // every writeback belongs to a writer the scoreboard still tracks
  a_wb_tracked: assert property (@(posedge clk) disable iff (!rst_n)
    commit.wb_valid && commit.wb_rd != '0 |-> pend_q[commit.wb_rd]);

endmodule

// File: mini_backend_if.sv
`timescale 1ns/1ps
`include "mini_backend_defs.svh"

interface issue_if;
  import mini_backend_pipe_pkg::*;

  logic   valid;
  logic   ready;
  issue_t payload;

  modport decode  (output valid, output payload, input ready);
  modport execute (input valid, input payload, output ready);
endinterface

interface exec_if;
  import mini_backend_pipe_pkg::*;

  logic    valid;
  logic    ready;
  result_t payload;

  modport execute (output valid, output payload, input ready);
  modport result  (input valid, input payload, output ready);
endinterface

// writeback and flush back from the retire stage
interface commit_if;
  import mini_backend_isa_pkg::*;

  logic                wb_valid;
  reg_idx_t            wb_rd;
  logic [`MB_XLEN-1:0] wb_data;
  logic                flush;
  logic                epoch;

  modport result  (output wb_valid, output wb_rd, output wb_data, output flush, output epoch);
  modport decode  (input wb_valid, input wb_rd, input wb_data, input flush, input epoch);
  modport execute (input flush);
endinterface

// File: mini_backend_pipe_pkg.sv
`include "mini_backend_defs.svh"

package mini_backend_pipe_pkg;

  // decode to execute
  typedef struct packed {
    logic [`MB_XLEN-1:0]            pc;
    mini_backend_isa_pkg::opcode_t  opcode;
    mini_backend_isa_pkg::reg_idx_t rd;
    logic                           we;
    logic                           illegal;
    logic [`MB_XLEN-1:0]            op_a;
    logic [`MB_XLEN-1:0]            op_b;
    logic [`MB_XLEN-1:0]            imm;
  } issue_t;

  // execute to result
  typedef struct packed {
    logic [`MB_XLEN-1:0]            pc;
    mini_backend_isa_pkg::reg_idx_t rd;
    logic                           we;
    logic                           illegal;
    logic [`MB_XLEN-1:0]            data;
    logic                           br_taken;
    logic [`MB_XLEN-1:0]            br_target;
  } result_t;

endpackage

// File: mini_backend_isa_pkg.sv
`include "mini_backend_defs.svh"

package mini_backend_isa_pkg;

  // codes 13 to 15 are illegal
  typedef enum logic [`MB_OPC_W-1:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SLT  = 4'd7,
    OP_ADDI = 4'd8,
    OP_ORI  = 4'd9,
    OP_LUI  = 4'd10,
    OP_BEQ  = 4'd11,
    OP_BNE  = 4'd12
  } opcode_t;

  // r0 always reads zero
  typedef logic [`MB_REG_W-1:0] reg_idx_t;

  typedef struct packed {
    opcode_t                            opcode;
    reg_idx_t                           rd;
    reg_idx_t                           rs1;
    reg_idx_t                           rs2;
    logic [`MB_OPC_LSB-3*`MB_REG_W-1:0] unused;
  } instr_r_t;

  // branches compare rs1 against the rd field
  typedef struct packed {
    opcode_t               opcode;
    reg_idx_t              rd;
    reg_idx_t              rs1;
    logic [`MB_REG_W-1:0]  unused;
    logic [`MB_IMM_W-1:0]  imm;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

// File: mini_backend_defs.svh
`ifndef MINI_BACKEND_DEFS_SVH
`define MINI_BACKEND_DEFS_SVH

// datapath and register file
`define MB_XLEN    32
`define MB_NREGS   16

// instruction word layout
`define MB_OPC_W   4
`define MB_OPC_LSB 28
`define MB_REG_W   4
`define MB_IMM_W   16

`endif
